/* Makefile */
VERILATOR ?= verilator
TOP       := reservation_station_tb
FILELIST  := vlog.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
BUILD     := obj_dir
LOG       := sim.log
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* design/reservation_station.sv */
// reservation station top level
// dispatch router, entry array and issue router joined by two selectors
`timescale 1ns/10ps
`default_nettype none

module reservation_station #(
    parameter int WAYS    = rs_pkg::WAYS_DEFAULT,
    parameter int ENTRIES = rs_pkg::ENTRIES_DEFAULT,
    parameter int XLEN    = rs_pkg::XLEN_DEFAULT,
    parameter int TAG_W   = rs_pkg::TAG_W_DEFAULT
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire logic [WAYS-1:0]                      disp_valid,
    input  wire rs_pkg::alu_func_t [WAYS-1:0]         disp_func,
    input  wire logic [WAYS-1:0][TAG_W-1:0]           disp_dest,
    input  wire logic [WAYS-1:0][XLEN-1:0]            disp_opa,
    input  wire logic [WAYS-1:0]                      disp_opa_ready,
    input  wire logic [WAYS-1:0][XLEN-1:0]            disp_opb,
    input  wire logic [WAYS-1:0]                      disp_opb_ready,
    input  wire logic [WAYS-1:0]                      cdb_valid,
    input  wire logic [WAYS-1:0][TAG_W-1:0]           cdb_tag,
    input  wire logic [WAYS-1:0][XLEN-1:0]            cdb_data,
    input  wire logic [WAYS-1:0]                      alu_busy,
    output logic      [WAYS-1:0]                      issue_valid,
    output rs_pkg::alu_func_t [WAYS-1:0]              issue_func,
    output logic      [WAYS-1:0][TAG_W-1:0]           issue_dest,
    output logic      [WAYS-1:0][XLEN-1:0]            issue_opa,
    output logic      [WAYS-1:0][XLEN-1:0]            issue_opb,
    output logic      [$clog2(ENTRIES+1)-1:0]         free_count
);

    logic [ENTRIES-1:0]                entry_free;
    logic [ENTRIES-1:0]                entry_ready;
    logic [WAYS-1:0][ENTRIES-1:0]      load_gnt_bus;
    logic [WAYS-1:0][ENTRIES-1:0]      issue_gnt_bus;
    logic [ENTRIES-1:0]                entry_load;
    logic [ENTRIES-1:0]                entry_clear;
    rs_pkg::alu_func_t [ENTRIES-1:0]   ld_func;
    logic [ENTRIES-1:0][TAG_W-1:0]     ld_dest;
    logic [ENTRIES-1:0][XLEN-1:0]      ld_opa;
    logic [ENTRIES-1:0][XLEN-1:0]      ld_opb;
    logic [ENTRIES-1:0]                ld_opa_ready;
    logic [ENTRIES-1:0]                ld_opb_ready;
    rs_pkg::alu_func_t [ENTRIES-1:0]   st_func;
    logic [ENTRIES-1:0][TAG_W-1:0]     st_dest;
    logic [ENTRIES-1:0][XLEN-1:0]      st_opa;
    logic [ENTRIES-1:0][XLEN-1:0]      st_opb;
    logic [$clog2(WAYS+1)-1:0]         issued_count;

    // free entries to dispatch ways
    rs_psel #(.WAYS(WAYS), .ENTRIES(ENTRIES)) u_in_sel (
        .req     (entry_free),
        .gnt     (),
        .gnt_bus (load_gnt_bus)
    );

    rs_dispatch #(.WAYS(WAYS), .ENTRIES(ENTRIES), .XLEN(XLEN), .TAG_W(TAG_W)) u_dispatch (
        .clock           (clock),
        .reset           (reset),
        .disp_valid      (disp_valid),
        .disp_func       (disp_func),
        .disp_dest       (disp_dest),
        .disp_opa        (disp_opa),
        .disp_opa_ready  (disp_opa_ready),
        .disp_opb        (disp_opb),
        .disp_opb_ready  (disp_opb_ready),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_data        (cdb_data),
        .load_gnt_bus    (load_gnt_bus),
        .issued_count    (issued_count),
        .entry_load      (entry_load),
        .entry_func      (ld_func),
        .entry_dest      (ld_dest),
        .entry_opa       (ld_opa),
        .entry_opb       (ld_opb),
        .entry_opa_ready (ld_opa_ready),
        .entry_opb_ready (ld_opb_ready),
        .free_count      (free_count)
    );

    for (genvar i = 0; i < ENTRIES; i++) begin : g_entry
        rs_entry #(.WAYS(WAYS), .XLEN(XLEN), .TAG_W(TAG_W)) u_entry (
            .clock          (clock),
            .reset          (reset),
            .load           (entry_load[i]),
            .clear          (entry_clear[i]),
            .load_func      (ld_func[i]),
            .load_dest      (ld_dest[i]),
            .load_opa       (ld_opa[i]),
            .load_opb       (ld_opb[i]),
            .load_opa_ready (ld_opa_ready[i]),
            .load_opb_ready (ld_opb_ready[i]),
            .cdb_valid      (cdb_valid),
            .cdb_tag        (cdb_tag),
            .cdb_data       (cdb_data),
            .free           (entry_free[i]),
            .ready          (entry_ready[i]),
            .func           (st_func[i]),
            .dest           (st_dest[i]),
            .opa            (st_opa[i]),
            .opb            (st_opb[i])
        );
    end

    // ready entries to issue rows
    rs_psel #(.WAYS(WAYS), .ENTRIES(ENTRIES)) u_out_sel (
        .req     (entry_ready),
        .gnt     (),
        .gnt_bus (issue_gnt_bus)
    );

    rs_issue #(.WAYS(WAYS), .ENTRIES(ENTRIES), .XLEN(XLEN), .TAG_W(TAG_W)) u_issue (
        .issue_gnt_bus (issue_gnt_bus),
        .entry_func    (st_func),
        .entry_dest    (st_dest),
        .entry_opa     (st_opa),
        .entry_opb     (st_opb),
        .alu_busy      (alu_busy),
        .issue_valid   (issue_valid),
        .issue_func    (issue_func),
        .issue_dest    (issue_dest),
        .issue_opa     (issue_opa),
        .issue_opb     (issue_opb),
        .entry_clear   (entry_clear),
        .issued_count  (issued_count)
    );

endmodule

`default_nettype wire

/* design/rs_dispatch.sv */
// dispatch side of the reservation station
// CDB bypass on incoming operands, steering of ways to granted free
// entries, and the free entry counter
`timescale 1ns/10ps
`default_nettype none

module rs_dispatch #(
    parameter int WAYS    = 2,
    parameter int ENTRIES = 8,
    parameter int XLEN    = 32,
    parameter int TAG_W   = 6
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire logic [WAYS-1:0]                      disp_valid,
    input  wire rs_pkg::alu_func_t [WAYS-1:0]         disp_func,
    input  wire logic [WAYS-1:0][TAG_W-1:0]           disp_dest,
    input  wire logic [WAYS-1:0][XLEN-1:0]            disp_opa,
    input  wire logic [WAYS-1:0]                      disp_opa_ready,
    input  wire logic [WAYS-1:0][XLEN-1:0]            disp_opb,
    input  wire logic [WAYS-1:0]                      disp_opb_ready,
    input  wire logic [WAYS-1:0]                      cdb_valid,
    input  wire logic [WAYS-1:0][TAG_W-1:0]           cdb_tag,
    input  wire logic [WAYS-1:0][XLEN-1:0]            cdb_data,
    input  wire logic [WAYS-1:0][ENTRIES-1:0]         load_gnt_bus,
    input  wire logic [$clog2(WAYS+1)-1:0]            issued_count,
    output logic      [ENTRIES-1:0]                   entry_load,
    output rs_pkg::alu_func_t [ENTRIES-1:0]           entry_func,
    output logic      [ENTRIES-1:0][TAG_W-1:0]        entry_dest,
    output logic      [ENTRIES-1:0][XLEN-1:0]         entry_opa,
    output logic      [ENTRIES-1:0][XLEN-1:0]         entry_opb,
    output logic      [ENTRIES-1:0]                   entry_opa_ready,
    output logic      [ENTRIES-1:0]                   entry_opb_ready,
    output logic      [$clog2(ENTRIES+1)-1:0]         free_count
);

    localparam int CNT_W  = $clog2(WAYS + 1);
    localparam int FREE_W = $clog2(ENTRIES + 1);

    logic [WAYS-1:0][XLEN-1:0] byp_opa;
    logic [WAYS-1:0][XLEN-1:0] byp_opb;
    logic [WAYS-1:0]           byp_opa_ready;
    logic [WAYS-1:0]           byp_opb_ready;
    logic [CNT_W-1:0]          disp_count;

    // results broadcast this cycle would otherwise be missed
    always_comb begin
        for (int k = 0; k < WAYS; k++) begin
            byp_opa[k]       = disp_opa[k];
            byp_opb[k]       = disp_opb[k];
            byp_opa_ready[k] = disp_opa_ready[k];
            byp_opb_ready[k] = disp_opb_ready[k];
            for (int w = 0; w < WAYS; w++) begin
                if (!disp_opa_ready[k] && cdb_valid[w]
                        && cdb_tag[w] == disp_opa[k][TAG_W-1:0]) begin
                    byp_opa[k]       = cdb_data[w];
                    byp_opa_ready[k] = 1'b1;
                end
                if (!disp_opb_ready[k] && cdb_valid[w]
                        && cdb_tag[w] == disp_opb[k][TAG_W-1:0]) begin
                    byp_opb[k]       = cdb_data[w];
                    byp_opb_ready[k] = 1'b1;
                end
            end
        end
    end

    // way k lands in the entry of grant row k
    always_comb begin
        entry_load      = '0;
        entry_func      = '0;
        entry_dest      = '0;
        entry_opa       = '0;
        entry_opb       = '0;
        entry_opa_ready = '0;
        entry_opb_ready = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            for (int k = 0; k < WAYS; k++) begin
                if (disp_valid[k] && load_gnt_bus[k][i]) begin
                    entry_load[i]      = 1'b1;
                    entry_func[i]      = disp_func[k];
                    entry_dest[i]      = disp_dest[k];
                    entry_opa[i]       = byp_opa[k];
                    entry_opb[i]       = byp_opb[k];
                    entry_opa_ready[i] = byp_opa_ready[k];
                    entry_opb_ready[i] = byp_opb_ready[k];
                end
            end
        end
    end

    // only ways that actually found an entry
    always_comb begin
        disp_count = '0;
        for (int k = 0; k < WAYS; k++) begin
            if (disp_valid[k] && |load_gnt_bus[k]) begin
                disp_count = disp_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            free_count <= FREE_W'(ENTRIES);
        end else begin
            free_count <= free_count - FREE_W'(disp_count) + FREE_W'(issued_count);
        end
    end

endmodule

`default_nettype wire

/* design/rs_entry.sv */
// reservation station slot
// holds one instruction and snoops the CDB for its pending operands
`timescale 1ns/10ps
`default_nettype none

module rs_entry #(
    parameter int WAYS  = 2,
    parameter int XLEN  = 32,
    parameter int TAG_W = 6
) (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         load,
    input  wire logic                         clear,
    input  wire rs_pkg::alu_func_t            load_func,
    input  wire logic [TAG_W-1:0]             load_dest,
    input  wire logic [XLEN-1:0]              load_opa,
    input  wire logic [XLEN-1:0]              load_opb,
    input  wire logic                         load_opa_ready,
    input  wire logic                         load_opb_ready,
    input  wire logic [WAYS-1:0]              cdb_valid,
    input  wire logic [WAYS-1:0][TAG_W-1:0]   cdb_tag,
    input  wire logic [WAYS-1:0][XLEN-1:0]    cdb_data,
    output logic                              free,
    output logic                              ready,
    output rs_pkg::alu_func_t                 func,
    output logic      [TAG_W-1:0]             dest,
    output logic      [XLEN-1:0]              opa,
    output logic      [XLEN-1:0]              opb
);

    logic            busy;
    logic            opa_rdy;
    logic            opb_rdy;
    logic [XLEN-1:0] opa_next;
    logic [XLEN-1:0] opb_next;
    logic            opa_rdy_next;
    logic            opb_rdy_next;

    // pending operand holds its tag in the low bits
    always_comb begin
        opa_next     = opa;
        opb_next     = opb;
        opa_rdy_next = opa_rdy;
        opb_rdy_next = opb_rdy;
        for (int w = 0; w < WAYS; w++) begin
            if (!opa_rdy && cdb_valid[w] && cdb_tag[w] == opa[TAG_W-1:0]) begin
                opa_next     = cdb_data[w];
                opa_rdy_next = 1'b1;
            end
            if (!opb_rdy && cdb_valid[w] && cdb_tag[w] == opb[TAG_W-1:0]) begin
                opb_next     = cdb_data[w];
                opb_rdy_next = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            busy    <= 1'b0;
            opa_rdy <= 1'b0;
            opb_rdy <= 1'b0;
        end else if (load) begin
            busy    <= 1'b1;
            opa_rdy <= load_opa_ready;
            opb_rdy <= load_opb_ready;
        end else if (busy) begin
            opa_rdy <= opa_rdy_next;
            opb_rdy <= opb_rdy_next;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            func <= load_func;
            dest <= load_dest;
            opa  <= load_opa;
            opb  <= load_opb;
        end else if (busy) begin
            opa <= opa_next;
            opb <= opb_next;
        end
    end

    assign free  = ~busy;
    assign ready = busy & opa_rdy & opb_rdy;

endmodule

`default_nettype wire

/* design/rs_issue.sv */
// issue side of the reservation station
// places granted ready entries on free ALU ports and clears them
`timescale 1ns/10ps
`default_nettype none

module rs_issue #(
    parameter int WAYS    = 2,
    parameter int ENTRIES = 8,
    parameter int XLEN    = 32,
    parameter int TAG_W   = 6
) (
    input  wire logic [WAYS-1:0][ENTRIES-1:0]         issue_gnt_bus,
    input  wire rs_pkg::alu_func_t [ENTRIES-1:0]      entry_func,
    input  wire logic [ENTRIES-1:0][TAG_W-1:0]        entry_dest,
    input  wire logic [ENTRIES-1:0][XLEN-1:0]         entry_opa,
    input  wire logic [ENTRIES-1:0][XLEN-1:0]         entry_opb,
    input  wire logic [WAYS-1:0]                      alu_busy,
    output logic      [WAYS-1:0]                      issue_valid,
    output rs_pkg::alu_func_t [WAYS-1:0]              issue_func,
    output logic      [WAYS-1:0][TAG_W-1:0]           issue_dest,
    output logic      [WAYS-1:0][XLEN-1:0]            issue_opa,
    output logic      [WAYS-1:0][XLEN-1:0]            issue_opb,
    output logic      [ENTRIES-1:0]                   entry_clear,
    output logic      [$clog2(WAYS+1)-1:0]            issued_count
);

    rs_pkg::alu_func_t [WAYS-1:0] row_func;
    logic [WAYS-1:0][TAG_W-1:0]   row_dest;
    logic [WAYS-1:0][XLEN-1:0]    row_opa;
    logic [WAYS-1:0][XLEN-1:0]    row_opb;

    // one-hot row to entry payload
    always_comb begin
        row_func = '0;
        row_dest = '0;
        row_opa  = '0;
        row_opb  = '0;
        for (int r = 0; r < WAYS; r++) begin
            for (int i = 0; i < ENTRIES; i++) begin
                if (issue_gnt_bus[r][i]) begin
                    row_func[r] = entry_func[i];
                    row_dest[r] = entry_dest[i];
                    row_opa[r]  = entry_opa[i];
                    row_opb[r]  = entry_opb[i];
                end
            end
        end
    end

    // each row takes the lowest idle port above the last placement
    always_comb begin
        int  next_port;
        logic placed;
        issue_valid  = '0;
        issue_func   = '0;
        issue_dest   = '0;
        issue_opa    = '0;
        issue_opb    = '0;
        entry_clear  = '0;
        issued_count = '0;
        next_port    = 0;
        for (int r = 0; r < WAYS; r++) begin
            placed = 1'b0;
            for (int p = 0; p < WAYS; p++) begin
                if (|issue_gnt_bus[r] && !placed && p >= next_port && !alu_busy[p]) begin
                    placed         = 1'b1;
                    issue_valid[p] = 1'b1;
                    issue_func[p]  = row_func[r];
                    issue_dest[p]  = row_dest[r];
                    issue_opa[p]   = row_opa[r];
                    issue_opb[p]   = row_opb[r];
                    entry_clear    = entry_clear | issue_gnt_bus[r];
                    issued_count   = issued_count + 1'b1;
                    next_port      = p + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/rs_pkg.sv */
// reservation station shared definitions
// default sizes and the ALU operation code carried with each instruction
`default_nettype none

package rs_pkg;

    // dispatch, CDB and issue width
    localparam int WAYS_DEFAULT    = 2;
    localparam int ENTRIES_DEFAULT = 8;
    localparam int XLEN_DEFAULT    = 32;
    // physical register tag width
    localparam int TAG_W_DEFAULT   = 6;

    // passed through the station untouched
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLL  = 4'h5,
        ALU_SRL  = 4'h6,
        ALU_SRA  = 4'h7,
        ALU_SLT  = 4'h8,
        ALU_SLTU = 4'h9,
        ALU_MUL  = 4'ha,
        ALU_MULH = 4'hb,
        ALU_PASS = 4'hc
    } alu_func_t;

endpackage

`default_nettype wire

/* design/rs_psel.sv */
// multi-grant priority selector
// hands up to WAYS set requests to grant rows, lowest index first
`timescale 1ns/10ps
`default_nettype none

module rs_psel #(
    parameter int WAYS    = 2,
    parameter int ENTRIES = 8
) (
    input  wire logic [ENTRIES-1:0]           req,
    output logic      [ENTRIES-1:0]           gnt,
    output logic      [WAYS-1:0][ENTRIES-1:0] gnt_bus
);

    // k-th set request goes to row k
    always_comb begin
        int row;
        gnt_bus = '0;
        row = 0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (req[i] && row < WAYS) begin
                gnt_bus[row][i] = 1'b1;
                row = row + 1;
            end
        end
    end

    always_comb begin
        gnt = '0;
        for (int k = 0; k < WAYS; k++) begin
            gnt = gnt | gnt_bus[k];
        end
    end

endmodule

`default_nettype wire

/* tests/reservation_station_tb.sv */
// reservation station testbench
// random dispatch, CDB traffic and ALU back-pressure, checked against
// a per-tag model of the waiting instructions
`timescale 1ns/10ps
`default_nettype none

module reservation_station_tb;

    localparam int WAYS         = rs_pkg::WAYS_DEFAULT;
    localparam int ENTRIES      = rs_pkg::ENTRIES_DEFAULT;
    localparam int XLEN         = rs_pkg::XLEN_DEFAULT;
    localparam int TAG_W        = rs_pkg::TAG_W_DEFAULT;
    localparam int NTAGS        = 1 << TAG_W;
    localparam int FREE_W       = $clog2(ENTRIES + 1);
    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES  = 3000;
    localparam int DRAIN_CYCLES = 200;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES + DRAIN_CYCLES + 10) * PERIOD
                                  + 2000;

    logic                         clock;
    logic                         reset;
    logic [WAYS-1:0]              disp_valid;
    rs_pkg::alu_func_t [WAYS-1:0] disp_func;
    logic [WAYS-1:0][TAG_W-1:0]   disp_dest;
    logic [WAYS-1:0][XLEN-1:0]    disp_opa;
    logic [WAYS-1:0]              disp_opa_ready;
    logic [WAYS-1:0][XLEN-1:0]    disp_opb;
    logic [WAYS-1:0]              disp_opb_ready;
    logic [WAYS-1:0]              cdb_valid;
    logic [WAYS-1:0][TAG_W-1:0]   cdb_tag;
    logic [WAYS-1:0][XLEN-1:0]    cdb_data;
    logic [WAYS-1:0]              alu_busy;
    logic [WAYS-1:0]              issue_valid;
    rs_pkg::alu_func_t [WAYS-1:0] issue_func;
    logic [WAYS-1:0][TAG_W-1:0]   issue_dest;
    logic [WAYS-1:0][XLEN-1:0]    issue_opa;
    logic [WAYS-1:0][XLEN-1:0]    issue_opb;
    logic [FREE_W-1:0]            free_count;

    // model state indexed by destination tag
    bit                inflight [NTAGS];
    bit                pending  [NTAGS];
    rs_pkg::alu_func_t m_func   [NTAGS];
    logic [XLEN-1:0]   m_opa    [NTAGS];
    logic [XLEN-1:0]   m_opb    [NTAGS];
    bit                m_ra     [NTAGS];
    bit                m_rb     [NTAGS];

    logic [31:0] seed = 32'h1a591ec1;
    int          errors = 0;
    int          checks = 0;
    int          dispatched = 0;
    int          issued = 0;

    reservation_station #(
        .WAYS    (WAYS),
        .ENTRIES (ENTRIES),
        .XLEN    (XLEN),
        .TAG_W   (TAG_W)
    ) u_reservation_station (
        .clock          (clock),
        .reset          (reset),
        .disp_valid     (disp_valid),
        .disp_func      (disp_func),
        .disp_dest      (disp_dest),
        .disp_opa       (disp_opa),
        .disp_opa_ready (disp_opa_ready),
        .disp_opb       (disp_opb),
        .disp_opb_ready (disp_opb_ready),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .alu_busy       (alu_busy),
        .issue_valid    (issue_valid),
        .issue_func     (issue_func),
        .issue_dest     (issue_dest),
        .issue_opa      (issue_opa),
        .issue_opb      (issue_opb),
        .free_count     (free_count)
    );

    initial clock = 1'b0;
    always #(PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // first tag from start on that waits for a result or is free for reuse
    function automatic int pick_tag(input logic [31:0] start, input bit want_pending);
        int t;
        for (int i = 0; i < NTAGS; i++) begin
            t = int'((start + 32'(i)) % 32'(NTAGS));
            if (want_pending && pending[t]) begin
                return t;
            end
            if (!want_pending && !pending[t] && !inflight[t]) begin
                return t;
            end
        end
        return -1;
    endfunction

    // operand after the CDB of this cycle as {ready, value}
    function automatic logic [XLEN:0] resolve_operand(input logic rdy, input logic [XLEN-1:0] val);
        logic [XLEN:0] res;
        res = {rdy, val};
        for (int w = 0; w < WAYS; w++) begin
            if (!rdy && cdb_valid[w] && cdb_tag[w] == val[TAG_W-1:0]) begin
                res = {1'b1, cdb_data[w]};
            end
        end
        return res;
    endfunction

    function automatic int count_inflight();
        int n;
        n = 0;
        for (int t = 0; t < NTAGS; t++) begin
            n = n + int'(inflight[t]);
        end
        return n;
    endfunction

    function automatic int count_pending();
        int n;
        n = 0;
        for (int t = 0; t < NTAGS; t++) begin
            n = n + int'(pending[t]);
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic drive_inputs(input bit active);
        int          avail;
        int          n_disp;
        int          n_cdb;
        int          t;
        logic [31:0] r;
        disp_valid     = '0;
        disp_func      = '0;
        disp_dest      = '0;
        disp_opa       = '0;
        disp_opb       = '0;
        disp_opa_ready = '0;
        disp_opb_ready = '0;
        cdb_valid      = '0;
        cdb_tag        = '0;
        cdb_data       = '0;
        avail  = int'(free_count) < WAYS ? int'(free_count) : WAYS;
        n_disp = active ? int'((next_random() >> 8) % 32'(avail + 1)) : 0;
        // operands before the CDB so some wait on a tag broadcast in this cycle
        for (int k = 0; k < n_disp; k++) begin
            r = next_random();
            disp_func[k] = rs_pkg::alu_func_t'(4'(r % 32'd13));
            t = pick_tag(next_random(), 1'b1);
            disp_opa_ready[k] = r[20] || t < 0;
            disp_opa[k] = disp_opa_ready[k] ? XLEN'(next_random()) : XLEN'(t);
            t = pick_tag(next_random(), 1'b1);
            disp_opb_ready[k] = r[21] || t < 0;
            disp_opb[k] = disp_opb_ready[k] ? XLEN'(next_random()) : XLEN'(t);
        end
        n_cdb = active ? int'((next_random() >> 8) % 32'(WAYS + 1)) : WAYS;
        for (int w = 0; w < n_cdb; w++) begin
            t = pick_tag(next_random(), 1'b1);
            if (t >= 0) begin
                cdb_valid[w] = 1'b1;
                cdb_tag[w]   = TAG_W'(t);
                cdb_data[w]  = XLEN'(next_random());
                pending[t]   = 1'b0;
            end
        end
        for (int k = 0; k < n_disp; k++) begin
            t = pick_tag(next_random(), 1'b0);
            if (t >= 0) begin
                disp_valid[k] = 1'b1;
                disp_dest[k]  = TAG_W'(t);
                pending[t]    = 1'b1;
            end
        end
        alu_busy = active ? WAYS'(next_random() >> 12) & WAYS'(next_random() >> 12) : '0;
    endtask

    // compare the issue ports with the model and then advance the model
    always @(posedge clock) begin
        int ready_cnt;
        int idle_cnt;
        int exp_cnt;
        int live;
        int d;
        if (!reset) begin
            ready_cnt = 0;
            live      = count_inflight();
            idle_cnt  = $countones(~alu_busy);
            for (int t = 0; t < NTAGS; t++) begin
                if (inflight[t] && m_ra[t] && m_rb[t]) begin
                    ready_cnt++;
                end
            end
            exp_cnt = ready_cnt < idle_cnt ? ready_cnt : idle_cnt;
            check_value("issue_valid count", XLEN'($countones(issue_valid)), XLEN'(exp_cnt));
            check_value("free_count", XLEN'(free_count), XLEN'(ENTRIES - live));
            for (int p = 0; p < WAYS; p++) begin
                if (issue_valid[p]) begin
                    d = int'(issue_dest[p]);
                    check_true(!alu_busy[p], $sformatf("port %0d issued while busy", p));
                    check_true(inflight[d] && m_ra[d] && m_rb[d],
                        $sformatf("tag %0h issued without both operands resolved", d));
                    check_value($sformatf("issue_func[%0d]", p), XLEN'(issue_func[p]),
                        XLEN'(m_func[d]));
                    check_value($sformatf("issue_opa[%0d]", p), issue_opa[p], m_opa[d]);
                    check_value($sformatf("issue_opb[%0d]", p), issue_opb[p], m_opb[d]);
                    inflight[d] = 1'b0;
                    issued++;
                end
            end
            for (int t = 0; t < NTAGS; t++) begin
                if (inflight[t]) begin
                    {m_ra[t], m_opa[t]} = resolve_operand(m_ra[t], m_opa[t]);
                    {m_rb[t], m_opb[t]} = resolve_operand(m_rb[t], m_opb[t]);
                end
            end
            for (int k = 0; k < WAYS; k++) begin
                if (disp_valid[k]) begin
                    d = int'(disp_dest[k]);
                    inflight[d] = 1'b1;
                    m_func[d]   = disp_func[k];
                    {m_ra[d], m_opa[d]} = resolve_operand(disp_opa_ready[k], disp_opa[k]);
                    {m_rb[d], m_opb[d]} = resolve_operand(disp_opb_ready[k], disp_opb[k]);
                    dispatched++;
                end
            end
        end
    end

    initial begin
        int c;
        int assert_errors;
        reset          = 1'b1;
        disp_valid     = '0;
        disp_func      = '0;
        disp_dest      = '0;
        disp_opa       = '0;
        disp_opb       = '0;
        disp_opa_ready = '0;
        disp_opb_ready = '0;
        cdb_valid      = '0;
        cdb_tag        = '0;
        cdb_data       = '0;
        alu_busy       = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        check_value("free_count", XLEN'(free_count), XLEN'(ENTRIES));
        check_value("issue_valid", XLEN'(issue_valid), '0);
        reset = 1'b0;
        for (int i = 0; i < TEST_CYCLES; i++) begin
            drive_inputs(1'b1);
            @(negedge clock);
        end
        // drain with every pending result broadcast and no back-pressure
        c = 0;
        while (c < DRAIN_CYCLES && (count_inflight() > 0 || count_pending() > 0)) begin
            drive_inputs(1'b0);
            @(negedge clock);
            c++;
        end
        drive_inputs(1'b0);
        repeat (2) @(negedge clock);
        check_true(count_inflight() == 0, "instructions left in the station after the drain");
        check_value("free_count", XLEN'(free_count), XLEN'(ENTRIES));
        check_true(dispatched == issued, "dispatched and issued totals differ");
        check_true(dispatched > 0, "no instruction was dispatched");
        assert_errors = u_reservation_station.u_rs_asserts.fail_count;
        $display("checks %0d  errors %0d  assertion failures %0d  dispatched %0d  issued %0d",
                 checks, errors, assert_errors, dispatched, issued);
        if (errors == 0 && assert_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the test did not finish", TIMEOUT_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/rs_asserts.sv */
// reservation station bound checks
// issue port back-pressure and free entry accounting
`timescale 1ns/10ps
`default_nettype none

module rs_asserts #(
    parameter int WAYS    = 2,
    parameter int ENTRIES = 8
) (
    input wire logic                         clock,
    input wire logic                         reset,
    input wire logic [WAYS-1:0]              disp_valid,
    input wire logic [WAYS-1:0]              alu_busy,
    input wire logic [WAYS-1:0]              issue_valid,
    input wire logic [$clog2(ENTRIES+1)-1:0] free_count
);

    // failed assertions so far
    int fail_count = 0;

    // a held port never issues
    busy_port_idle: assert property (@(posedge clock) disable iff (reset)
        (issue_valid & alu_busy) == '0)
        else begin
            $error("instruction issued on a busy ALU port");
            fail_count++;
        end

    free_count_max: assert property (@(posedge clock) disable iff (reset)
        int'(free_count) <= ENTRIES)
        else begin
            $error("free count above the number of entries");
            fail_count++;
        end

    // dispatched entries leave the pool and issued ones come back
    free_count_step: assert property (@(posedge clock) disable iff (reset)
        1'b1 |=> int'(free_count) == int'($past(free_count))
            - $countones($past(disp_valid)) + $countones($past(issue_valid)))
        else begin
            $error("free count did not follow dispatch and issue");
            fail_count++;
        end

    reset_state: assert property (@(posedge clock)
        reset |=> (issue_valid == '0 && int'(free_count) == ENTRIES))
        else begin
            $error("station not empty after reset");
            fail_count++;
        end

endmodule

bind reservation_station rs_asserts #(.WAYS(WAYS), .ENTRIES(ENTRIES)) u_rs_asserts (
    .clock       (clock),
    .reset       (reset),
    .disp_valid  (disp_valid),
    .alu_busy    (alu_busy),
    .issue_valid (issue_valid),
    .free_count  (free_count)
);

`default_nettype wire

/* vlog.f */
design/rs_pkg.sv
design/rs_psel.sv
design/rs_entry.sv
design/rs_dispatch.sv
design/rs_issue.sv
design/reservation_station.sv
tests/rs_asserts.sv
tests/reservation_station_tb.sv
